//--- design/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// datapath and instruction width
`define CPU_WORD_W 16

// general register file
`define CPU_REG_CNT 8
`define CPU_REG_AW 3

// program memory
`define CPU_PROG_DEPTH 128
`define CPU_PROG_AW 7

// the branch offset is sign extended to the word width and the
// resulting target is taken modulo the program depth, so only the
// low CPU_PROG_AW bits of any address sum matter

`endif

//--- design/isaPkg.sv
`include "cpu_defs.svh"

package isaPkg;

    ////////////////////////////////////////////////////////////
    // function and condition codes
    ////////////////////////////////////////////////////////////

    // 101 and 110 are reserved, they write nothing
    typedef enum logic [2:0] {
        ADD = 3'b000,
        NEG = 3'b001,
        OR  = 3'b010,
        NOT = 3'b011,
        MOV = 3'b100,
        LDI = 3'b111
    } aluFn;

    // odd codes from C upward are the inverted flag tests
    typedef enum logic [3:0] {
        NONE   = 4'b0000,
        ALWAYS = 4'b0001,
        C      = 4'b0010,
        NC     = 4'b0011,
        Z      = 4'b0100,
        NZ     = 4'b0101,
        V      = 4'b0110,
        NV     = 4'b0111,
        S      = 4'b1000,
        NS     = 4'b1001,
        HALT   = 4'b1111
    } condCode;

    ////////////////////////////////////////////////////////////
    // instruction formats
    ////////////////////////////////////////////////////////////

    // srcA:srcB double as the 6-bit immediate of LDI
    typedef struct packed {
        condCode                cond;
        aluFn                   fn;
        logic [`CPU_REG_AW-1:0] dst;
        logic [`CPU_REG_AW-1:0] srcA;
        logic [`CPU_REG_AW-1:0] srcB;
    } aluWord;

    typedef struct packed {
        condCode     cond;
        logic [11:0] offset;
    } branchWord;

    // same 16 bits seen as ALU or branch word
    typedef union packed {
        aluWord    alu;
        branchWord br;
    } instrWord;

endpackage

//--- design/corePkg.sv
package corePkg;

    ////////////////////////////////////////////////////////////
    // sequencer
    ////////////////////////////////////////////////////////////

    // one pass through FETCH, DECODE, EXEC per instruction
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        FETCH  = 2'b01,
        DECODE = 2'b10,
        EXEC   = 2'b11
    } seqState;

    ////////////////////////////////////////////////////////////
    // status flags
    ////////////////////////////////////////////////////////////

    // carry, zero, overflow, sign of the last ADD
    typedef struct packed {
        logic c;
        logic z;
        logic v;
        logic s;
    } aluFlags;

endpackage

//--- design/progRam.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module progRam (
    input  logic                    clk,
    input  logic                    loadValid,
    input  logic [`CPU_PROG_AW-1:0] loadAddr,
    input  logic [`CPU_WORD_W-1:0]  loadData,
    input  logic [`CPU_PROG_AW-1:0] fetchAddr,
    output logic [`CPU_WORD_W-1:0]  fetchData
);

    logic [`CPU_WORD_W-1:0] mem [`CPU_PROG_DEPTH];

    // load port writes whenever the strobe is up
    always_ff @(posedge clk)
    begin
        if (loadValid)
        begin
            mem[loadAddr] <= loadData;
        end
    end

    // fetch data shows up one cycle after the address
    always_ff @(posedge clk)
    begin
        fetchData <= mem[fetchAddr];
    end

endmodule

//--- design/regBank.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module regBank (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   wrEn,
    input  logic [`CPU_REG_AW-1:0] wrIdx,
    input  logic [`CPU_WORD_W-1:0] wrData,
    input  logic [`CPU_REG_AW-1:0] rdIdxA,
    input  logic [`CPU_REG_AW-1:0] rdIdxB,
    output logic [`CPU_WORD_W-1:0] rdA,
    output logic [`CPU_WORD_W-1:0] rdB
);

    logic [`CPU_WORD_W-1:0]  regs [`CPU_REG_CNT];
    logic [`CPU_REG_CNT-1:0] wrSel;

    // one-hot load enable per register
    assign wrSel = wrEn ? (`CPU_REG_CNT'(1) << wrIdx) : '0;

    always_ff @(posedge clk)
    begin
        for (int i = 0; i < `CPU_REG_CNT; i++)
        begin
            if (!rstN)
                regs[i] <= '0;
            else if (wrSel[i])
                regs[i] <= wrData;
        end
    end

    // both operands read straight out of the array
    assign rdA = regs[rdIdxA];
    assign rdB = regs[rdIdxB];

endmodule

//--- design/aluUnit.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module aluUnit (
    input  logic                   clk,
    input  logic                   rstN,
    input  isaPkg::instrWord       instr,
    input  logic [`CPU_WORD_W-1:0] rdA,
    input  logic [`CPU_WORD_W-1:0] rdB,
    input  logic                   execStrobe,
    output logic [`CPU_WORD_W-1:0] aluResult,
    output logic                   aluWrites,
    output corePkg::aluFlags       flags
);

    localparam int Msb = `CPU_WORD_W - 1;

    logic [`CPU_WORD_W:0] sum;
    logic [5:0]           imm;
    logic                 fnWrites;

    // extra bit keeps the carry out
    assign sum = {1'b0, rdA} + {1'b0, rdB};
    assign imm = {instr.alu.srcA, instr.alu.srcB};

    always_comb
    begin
        case (instr.alu.fn)
            isaPkg::ADD: aluResult = sum[Msb:0];
            isaPkg::NEG: aluResult = -rdB;
            isaPkg::OR:  aluResult = rdA | rdB;
            isaPkg::NOT: aluResult = ~rdB;
            isaPkg::MOV: aluResult = rdB;
            isaPkg::LDI: aluResult = {{(`CPU_WORD_W - 6){imm[5]}}, imm};
            default:     aluResult = '0;
        endcase
    end

    // reserved codes 101 and 110 fall through here
    assign fnWrites = (instr.alu.fn != 3'b101) && (instr.alu.fn != 3'b110);
    assign aluWrites = fnWrites && (instr.alu.cond == isaPkg::NONE);

    ////////////////////////////////////////////////////////////
    // flag register, ADD only
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!rstN)
            flags <= '0;
        else if (execStrobe && aluWrites && instr.alu.fn == isaPkg::ADD)
        begin
            flags.c <= sum[`CPU_WORD_W];
            flags.z <= (sum[Msb:0] == '0);
            // same-sign operands, sum flips sign
            flags.v <= (rdA[Msb] == rdB[Msb]) && (sum[Msb] != rdA[Msb]);
            flags.s <= sum[Msb];
        end
    end

endmodule

//--- design/branchUnit.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module branchUnit (
    input  isaPkg::instrWord        instr,
    input  logic [`CPU_PROG_AW-1:0] pc,
    input  corePkg::aluFlags        flags,
    output logic                    taken,
    output logic [`CPU_PROG_AW-1:0] target
);

    logic [`CPU_WORD_W-1:0] offsetExt;
    logic [`CPU_WORD_W-1:0] sum;

    // flag or inverted flag picked by the condition code
    always_comb
    begin
        case (instr.br.cond)
            isaPkg::ALWAYS: taken = 1'b1;
            isaPkg::C:      taken = flags.c;
            isaPkg::NC:     taken = !flags.c;
            isaPkg::Z:      taken = flags.z;
            isaPkg::NZ:     taken = !flags.z;
            isaPkg::V:      taken = flags.v;
            isaPkg::NV:     taken = !flags.v;
            isaPkg::S:      taken = flags.s;
            isaPkg::NS:     taken = !flags.s;
            default:        taken = 1'b0;
        endcase
    end

    // relative to the word after the branch, wraps at program depth
    assign offsetExt = {{(`CPU_WORD_W - 12){instr.br.offset[11]}}, instr.br.offset};
    assign sum = `CPU_WORD_W'(pc) + `CPU_WORD_W'(1) + offsetExt;
    assign target = sum[`CPU_PROG_AW-1:0];

endmodule

//--- design/cpuSequencer.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpuSequencer (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    start,
    input  logic [`CPU_WORD_W-1:0]  fetchData,
    input  logic [`CPU_WORD_W-1:0]  aluResult,
    input  logic                    aluWrites,
    input  logic                    taken,
    input  logic [`CPU_PROG_AW-1:0] target,
    output logic [`CPU_PROG_AW-1:0] fetchAddr,
    output isaPkg::instrWord        instr,
    output logic                    execStrobe,
    output logic                    wbValid,
    output logic [`CPU_REG_AW-1:0]  wbReg,
    output logic [`CPU_WORD_W-1:0]  wbData,
    output logic                    halted
);

    corePkg::seqState        state;
    logic [`CPU_PROG_AW-1:0] pc;
    logic                    isHalt;

    assign fetchAddr = pc;
    assign execStrobe = (state == corePkg::EXEC);
    assign isHalt = (instr.br.cond == isaPkg::HALT);

    // register write goes out during EXEC, lands on the closing edge
    assign wbValid = execStrobe && aluWrites;
    assign wbReg = instr.alu.dst;
    assign wbData = aluResult;

    ////////////////////////////////////////////////////////////
    // FSM, PC and halt flag
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            state <= corePkg::IDLE;
            pc <= '0;
            halted <= 1'b0;
        end
        else
        begin
            case (state)
                corePkg::IDLE:
                begin
                    if (start)
                    begin
                        pc <= '0;
                        halted <= 1'b0;
                        state <= corePkg::FETCH;
                    end
                end
                corePkg::FETCH:  state <= corePkg::DECODE;
                corePkg::DECODE: state <= corePkg::EXEC;
                corePkg::EXEC:
                begin
                    if (isHalt)
                    begin
                        halted <= 1'b1;
                        state <= corePkg::IDLE;
                    end
                    else
                    begin
                        // ALU words are never taken, so they fall through to pc+1
                        pc <= taken ? target : pc + 1'b1;
                        state <= corePkg::FETCH;
                    end
                end
                default: state <= corePkg::IDLE;
            endcase
        end
    end

    // IR picks up the fetched word in DECODE
    always_ff @(posedge clk)
    begin
        if (state == corePkg::DECODE)
            instr <= fetchData;
    end

endmodule

//--- design/cpuTop.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpuTop (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    loadValid,
    input  logic [`CPU_PROG_AW-1:0] loadAddr,
    input  logic [`CPU_WORD_W-1:0]  loadData,
    input  logic                    start,
    output logic                    wbValid,
    output logic [`CPU_REG_AW-1:0]  wbReg,
    output logic [`CPU_WORD_W-1:0]  wbData,
    output logic                    halted
);

    logic [`CPU_PROG_AW-1:0] fetchAddr;
    logic [`CPU_WORD_W-1:0]  fetchData;
    isaPkg::instrWord        instr;
    logic                    execStrobe;
    logic [`CPU_WORD_W-1:0]  rdA;
    logic [`CPU_WORD_W-1:0]  rdB;
    logic [`CPU_WORD_W-1:0]  aluResult;
    logic                    aluWrites;
    corePkg::aluFlags        flags;
    logic                    taken;
    logic [`CPU_PROG_AW-1:0] target;

    progRam prog (.clk, .loadValid, .loadAddr, .loadData, .fetchAddr, .fetchData);

    // writeback strobe doubles as the register file write enable
    regBank regs (.clk, .rstN, .wrEn(wbValid), .wrIdx(wbReg), .wrData(wbData),
                  .rdIdxA(instr.alu.srcA), .rdIdxB(instr.alu.srcB), .rdA, .rdB);

    aluUnit alu (.clk, .rstN, .instr, .rdA, .rdB, .execStrobe, .aluResult, .aluWrites, .flags);

    // fetch address is the PC of the word in the IR during EXEC
    branchUnit branch (.instr, .pc(fetchAddr), .flags, .taken, .target);

    cpuSequencer seq (.clk, .rstN, .start, .fetchData, .aluResult, .aluWrites, .taken,
                      .target, .fetchAddr, .instr, .execStrobe, .wbValid, .wbReg, .wbData,
                      .halted);

endmodule

//--- tb/cpuTb.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpuTb;

    localparam int ClkPeriod = 100;
    localparam int NumProgs = 3;
    localparam int NumWords = 74;
    localparam int NumExp = 50;
    // executed instructions over all four runs
    localparam int RunInstr = 15 + 27 + 50 + 50;
    localparam logic [`CPU_WORD_W-1:0] HaltWord = {isaPkg::HALT, 12'h000};

    logic                                clk;
    logic                                rstN;
    logic                                loadValid;
    logic [`CPU_PROG_AW-1:0]             loadAddr;
    logic [`CPU_WORD_W-1:0]              loadData;
    logic                                start;
    logic                                wbValid;
    logic [`CPU_REG_AW-1:0]              wbReg;
    logic [`CPU_WORD_W-1:0]              wbData;
    logic                                halted;
    logic [`CPU_WORD_W-1:0]              progTab [NumWords];
    logic [`CPU_REG_AW+`CPU_WORD_W-1:0]  expTab [NumExp];
    int                                  expLen [NumProgs];
    int                                  errCnt;
    int                                  checkCnt;

    cpuTop UUT (.clk, .rstN, .loadValid, .loadAddr, .loadData, .start,
                .wbValid, .wbReg, .wbData, .halted);

    initial
    begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // instruction encoders and trace entries
    ////////////////////////////////////////////////////////////

    function automatic logic [15:0] encodeAlu(logic [2:0] fn, int dst, int srcA, int srcB);
        return {isaPkg::NONE, fn, 3'(dst), 3'(srcA), 3'(srcB)};
    endfunction

    function automatic logic [15:0] encodeLdi(int dst, int imm);
        return {isaPkg::NONE, isaPkg::LDI, 3'(dst), 6'(imm)};
    endfunction

    function automatic logic [15:0] encodeBranch(isaPkg::condCode cond, int offset);
        return {cond, 12'(offset)};
    endfunction

    function automatic logic [18:0] traceEntry(int regIdx, logic [15:0] data);
        return {3'(regIdx), data};
    endfunction

    task automatic fillTables();
        progTab = '{
            // ALU functions with reserved codes at 7 and 8
            encodeLdi(1, 5), encodeLdi(2, -3), encodeAlu(isaPkg::ADD, 3, 1, 2),
            encodeAlu(isaPkg::NEG, 4, 0, 1), encodeAlu(isaPkg::OR, 5, 2, 4),
            encodeAlu(isaPkg::NOT, 6, 0, 1), encodeAlu(isaPkg::MOV, 7, 0, 2),
            encodeAlu(3'b101, 1, 1, 2), encodeAlu(3'b110, 2, 1, 2),
            encodeLdi(0, 31), encodeLdi(1, -32), encodeAlu(isaPkg::NEG, 2, 0, 1),
            encodeAlu(isaPkg::ADD, 3, 1, 2), encodeAlu(isaPkg::ADD, 5, 6, 7), HaltWord,
            // c and z set, then all clear, then c and s set
            encodeLdi(1, 1), encodeLdi(2, -1), encodeAlu(isaPkg::ADD, 3, 2, 1),
            encodeBranch(isaPkg::C, 1), encodeLdi(7, 1), encodeBranch(isaPkg::NC, 1),
            encodeLdi(7, 2), encodeBranch(isaPkg::Z, 1), encodeLdi(7, 3),
            encodeBranch(isaPkg::NZ, 1), encodeLdi(7, 4), encodeBranch(isaPkg::S, 1),
            encodeLdi(7, 5), encodeBranch(isaPkg::NS, 1), encodeLdi(7, 6),
            encodeBranch(isaPkg::NV, 1), encodeLdi(7, 7), encodeBranch(isaPkg::V, 1),
            encodeLdi(7, 8), encodeAlu(isaPkg::ADD, 3, 1, 1), encodeBranch(isaPkg::C, 1),
            encodeLdi(7, 9), encodeBranch(isaPkg::NC, 1), encodeLdi(7, 10),
            encodeBranch(isaPkg::Z, 1), encodeLdi(7, 11), encodeBranch(isaPkg::NZ, 1),
            encodeLdi(7, 12), encodeAlu(isaPkg::ADD, 3, 2, 2), encodeBranch(isaPkg::S, 1),
            encodeLdi(7, 13), encodeBranch(isaPkg::NS, 1), encodeLdi(7, 14), HaltWord,
            // doubling loop of 9 passes, overflow, then forward and wrapping jumps
            encodeLdi(1, -32), encodeLdi(2, 9), encodeLdi(3, -1),
            encodeAlu(isaPkg::ADD, 1, 1, 1), encodeAlu(isaPkg::ADD, 2, 2, 3),
            encodeBranch(isaPkg::Z, 1), encodeBranch(isaPkg::ALWAYS, -4),
            encodeAlu(isaPkg::ADD, 4, 1, 1), encodeBranch(isaPkg::V, 1), encodeLdi(7, 1),
            encodeAlu(isaPkg::ADD, 4, 4, 4), encodeBranch(isaPkg::V, 1), encodeLdi(7, 2),
            encodeBranch(isaPkg::NV, 1), encodeLdi(7, 3), encodeBranch(isaPkg::ALWAYS, 1),
            encodeLdi(7, 4), encodeBranch(isaPkg::ALWAYS, 130), encodeLdi(7, 5),
            encodeLdi(7, 6), encodeBranch(isaPkg::ALWAYS, -126), encodeLdi(7, 7),
            encodeLdi(7, 8), encodeLdi(7, 9), HaltWord
        };
        expTab = '{
            traceEntry(1, 16'h0005), traceEntry(2, 16'hFFFD), traceEntry(3, 16'h0002),
            traceEntry(4, 16'hFFFB), traceEntry(5, 16'hFFFF), traceEntry(6, 16'hFFFA),
            traceEntry(7, 16'hFFFD), traceEntry(0, 16'h001F), traceEntry(1, 16'hFFE0),
            traceEntry(2, 16'h0020), traceEntry(3, 16'h0000), traceEntry(5, 16'hFFF7),
            traceEntry(1, 16'h0001), traceEntry(2, 16'hFFFF), traceEntry(3, 16'h0000),
            traceEntry(7, 16'h0002), traceEntry(7, 16'h0004), traceEntry(7, 16'h0005),
            traceEntry(7, 16'h0008), traceEntry(3, 16'h0002), traceEntry(7, 16'h0009),
            traceEntry(7, 16'h000B), traceEntry(3, 16'hFFFE), traceEntry(7, 16'h000E),
            traceEntry(1, 16'hFFE0), traceEntry(2, 16'h0009), traceEntry(3, 16'hFFFF),
            traceEntry(1, 16'hFFC0), traceEntry(2, 16'h0008), traceEntry(1, 16'hFF80),
            traceEntry(2, 16'h0007), traceEntry(1, 16'hFF00), traceEntry(2, 16'h0006),
            traceEntry(1, 16'hFE00), traceEntry(2, 16'h0005), traceEntry(1, 16'hFC00),
            traceEntry(2, 16'h0004), traceEntry(1, 16'hF800), traceEntry(2, 16'h0003),
            traceEntry(1, 16'hF000), traceEntry(2, 16'h0002), traceEntry(1, 16'hE000),
            traceEntry(2, 16'h0001), traceEntry(1, 16'hC000), traceEntry(2, 16'h0000),
            traceEntry(4, 16'h8000), traceEntry(7, 16'h0001), traceEntry(4, 16'h0000),
            traceEntry(7, 16'h0003), traceEntry(7, 16'h0009)
        };
        expLen = '{12, 12, 26};
    endtask

    ////////////////////////////////////////////////////////////
    // checks, loader and trace checker
    ////////////////////////////////////////////////////////////

    task automatic checkValue(string name, logic [15:0] actual, logic [15:0] expected);
        checkCnt++;
        if (actual !== expected)
        begin
            errCnt++;
            $display("Error: %s is %h, expected %h at %0t", name, actual, expected, $time);
        end
    endtask

    task automatic reportFailure(string msg);
        errCnt++;
        $display("%s at %0t", msg, $time);
    endtask

    // words go in from address 0 up to and including the HALT word
    task automatic loadProgram(inout int idx);
        int addr;
        addr = 0;
        do
        begin
            // no writeback while the core sits idle
            @(negedge clk);
            checkValue("wbValid", 16'(wbValid), 16'h0000);
            @(posedge clk);
            #5;
            loadValid = 1'b1;
            loadAddr = 7'(addr);
            loadData = progTab[idx];
            addr++;
            idx++;
        end
        while (progTab[idx - 1] != HaltWord);
        @(posedge clk);
        #5;
        loadValid = 1'b0;
    endtask

    task automatic runProgram(int first, int count);
        int seen;
        seen = 0;
        start = 1'b1;
        @(posedge clk);
        #5;
        start = 1'b0;
        do
        begin
            @(negedge clk);
            if (wbValid && seen < count)
            begin
                checkValue("wbReg", 16'(wbReg), 16'(expTab[first + seen][18:16]));
                checkValue("wbData", wbData, expTab[first + seen][15:0]);
                seen++;
            end
            else if (wbValid)
                reportFailure($sformatf("writeback to r%0d beyond the expected trace", wbReg));
        end
        while (!halted);
        if (seen < count)
            reportFailure($sformatf("halted after %0d of %0d writebacks", seen, count));
        // core must stay quiet once halted
        repeat (2)
        begin
            @(negedge clk);
            checkValue("wbValid", 16'(wbValid), 16'h0000);
        end
        @(posedge clk);
        #5;
    endtask

    initial
    begin
        int wordIdx;
        int expIdx;
        int lastExp;
        rstN = 1'b0;
        loadValid = 1'b0;
        loadAddr = '0;
        loadData = '0;
        start = 1'b0;
        errCnt = 0;
        checkCnt = 0;
        wordIdx = 0;
        expIdx = 0;
        lastExp = 0;
        fillTables();
        repeat (10) @(posedge clk);
        #5;
        rstN = 1'b1;
        // core stays idle after reset
        repeat (5)
        begin
            @(negedge clk);
            checkValue("wbValid", 16'(wbValid), 16'h0000);
            checkValue("halted", 16'(halted), 16'h0000);
        end
        @(posedge clk);
        #5;
        for (int p = 0; p < NumProgs; p++)
        begin
            loadProgram(wordIdx);
            runProgram(expIdx, expLen[p]);
            lastExp = expIdx;
            expIdx += expLen[p];
        end
        // second start reruns what is still in program memory
        runProgram(lastExp, expLen[NumProgs - 1]);
        $display("%0d checks, %0d errors", checkCnt, errCnt);
        if (errCnt == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

    initial
    begin
        int limit;
        limit = RunInstr * 3 + NumWords + 50;
        repeat (limit) @(posedge clk);
        $display("watchdog expired after %0d cycles, the test did not finish", limit);
        $display("Result: FAILED");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+design
design/isaPkg.sv
design/corePkg.sv
design/progRam.sv
design/regBank.sv
design/aluUnit.sv
design/branchUnit.sv
design/cpuSequencer.sv
design/cpuTop.sv
tb/cpuTb.sv

//--- Bender.yml
package:
  name: cpu16

export_include_dirs:
  - design

sources:
  - design/isaPkg.sv
  - design/corePkg.sv
  - design/progRam.sv
  - design/regBank.sv
  - design/aluUnit.sv
  - design/branchUnit.sv
  - design/cpuSequencer.sv
  - design/cpuTop.sv
  - target: test
    files:
      - tb/cpuTb.sv
